// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_lcd_video \
    && ./obj_dir/Vtb_lcd_video | tee /dev/stderr | grep -F "** PASS **" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== src/frame_store.sv ====
module frame_store #(
    parameter int LCD_XSIZE = 96
) (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              col_we,
    input  lcd_pkg::fb_addr_t col_addr,
    input  lcd_pkg::lcd_col_t col_data,
    input  logic              frame_stored,
    input  lcd_pkg::fb_addr_t scan_addr,
    input  logic [2:0]        scan_row,
    output lcd_pkg::lcd_col_t col0,
    output lcd_pkg::lcd_col_t col1,
    output lcd_pkg::lcd_col_t col2,
    output lcd_pkg::lcd_col_t col3,
    output logic [2:0]        row_q
);
    import lcd_pkg::*;

    // room for eight bands of LCD_XSIZE columns
    localparam int DEPTH = LCD_XSIZE * 8;

    lcd_col_t  fb_mem [4][DEPTH];
    lcd_col_t  rd_q [4];
    fb_index_t wr_idx;

    //////////////////////////////////////////////////////////////////////
    // ring write side
    //////////////////////////////////////////////////////////////////////

    // next capture goes to the following buffer, oldest one gets replaced
    always_ff @(posedge clk_sys)
    begin
        if (reset)
            wr_idx <= '0;
        else if (frame_stored)
            wr_idx <= wr_idx + 1'b1;
    end

    always_ff @(posedge clk_sys)
    begin
        if (col_we)
            fb_mem[wr_idx][col_addr] <= col_data;
    end

    //////////////////////////////////////////////////////////////////////
    // scan read side
    //////////////////////////////////////////////////////////////////////

    // all four buffers read at the same scan address every clock
    always_ff @(posedge clk_sys)
    begin
        for (int i = 0; i < 4; i++)
            rd_q[i] <= fb_mem[i][scan_addr];
        // row follows the read latency
        row_q <= scan_row;
    end

    assign col0 = rd_q[0];
    assign col1 = rd_q[1];
    assign col2 = rd_q[2];
    assign col3 = rd_q[3];

endmodule

// ==== src/lcd_capture.sv ====
module lcd_capture #(
    parameter int LCD_XSIZE = 96,
    parameter int LCD_YSIZE = 64
) (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              frame_done,
    input  lcd_pkg::lcd_col_t wb_dat,
    input  logic              wb_ack,
    output logic              wb_cyc,
    output logic              wb_stb,
    output lcd_pkg::fb_addr_t wb_adr,
    output logic              col_we,
    output lcd_pkg::fb_addr_t col_addr,
    output lcd_pkg::lcd_col_t col_data,
    output logic              frame_stored
);
    import lcd_pkg::*;

    // 8 pixel rows per lcd column
    localparam int BANDS = LCD_YSIZE / 8;

    capture_state_t state;
    logic           pending;
    raster_t        x_cnt;
    raster_t        band_cnt;
    logic           last_col;

    // address only moves in ST_ADVANCE, so it is stable while stb is high
    assign wb_adr   = fb_addr_t'(band_cnt * LCD_XSIZE + x_cnt);
    assign last_col = (x_cnt == raster_t'(LCD_XSIZE - 1)) &&
                      (band_cnt == raster_t'(BANDS - 1));

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            state        <= ST_IDLE;
            pending      <= 1'b0;
            x_cnt        <= '0;
            band_cnt     <= '0;
            wb_cyc       <= 1'b0;
            wb_stb       <= 1'b0;
            col_we       <= 1'b0;
            frame_stored <= 1'b0;
        end
        else
        begin
            // single cycle strobes
            col_we       <= 1'b0;
            frame_stored <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    // first request goes out the cycle after the latch
                    if (pending)
                    begin
                        pending <= 1'b0;
                        wb_cyc  <= 1'b1;
                        wb_stb  <= 1'b1;
                        state   <= ST_REQUEST;
                    end
                    else if (frame_done)
                    begin
                        pending <= 1'b1;
                    end
                end

                ST_REQUEST:
                begin
                    // slave wait states just hold the request
                    if (wb_ack)
                    begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        col_we <= 1'b1;
                        state  <= ST_ADVANCE;
                    end
                end

                ST_ADVANCE:
                begin
                    // bus is idle this cycle
                    if (last_col)
                    begin
                        x_cnt        <= '0;
                        band_cnt     <= '0;
                        frame_stored <= 1'b1;
                        state        <= ST_IDLE;
                    end
                    else
                    begin
                        if (x_cnt == raster_t'(LCD_XSIZE - 1))
                        begin
                            x_cnt    <= '0;
                            band_cnt <= band_cnt + 1'b1;
                        end
                        else
                        begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= ST_REQUEST;
                    end
                end

                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // column payload, taken on the acknowledge cycle
    always_ff @(posedge clk_sys)
    begin
        if ((state == ST_REQUEST) && wb_ack)
        begin
            col_addr <= wb_adr;
            col_data <= wb_dat;
        end
    end

endmodule

// ==== src/lcd_pkg.sv ====
package lcd_pkg;

    //////////////////////////////////////////////////////////////////////
    // lcd memory and frame buffer words
    //////////////////////////////////////////////////////////////////////

    // one lcd column, bit n is row n of an 8 row band
    typedef logic [7:0] lcd_col_t;

    // buffer column index, band * width + x
    typedef logic [9:0] fb_addr_t;

    // selects one of the four ring buffers
    typedef logic [1:0] fb_index_t;

    //////////////////////////////////////////////////////////////////////
    // video side
    //////////////////////////////////////////////////////////////////////

    // grey level, also used for the scaled "on" level
    typedef logic [7:0] pixel_t;

    // raw lcd contrast register
    typedef logic [5:0] contrast_t;

    // raster and scan position counters
    typedef logic [7:0] raster_t;

    // capture sequencer, one wishbone read per column
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_ADVANCE
    } capture_state_t;

endpackage

// ==== src/lcd_video_top.sv ====
module lcd_video_top #(
    parameter int H_TOTAL   = 140,
    parameter int V_TOTAL   = 119,
    parameter int LCD_XSIZE = 96,
    parameter int LCD_YSIZE = 64
) (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               frame_done,
    input  lcd_pkg::contrast_t contrast,
    output logic               wb_cyc,
    output logic               wb_stb,
    output lcd_pkg::fb_addr_t  wb_adr,
    input  lcd_pkg::lcd_col_t  wb_dat,
    input  logic               wb_ack,
    output logic               pix_ce,
    output logic               hsync,
    output logic               vsync,
    output logic               hblank,
    output logic               vblank,
    output lcd_pkg::pixel_t    pixel
);
    import lcd_pkg::*;

    // capture to buffer ring
    logic       col_we;
    fb_addr_t   col_addr;
    lcd_col_t   col_data;
    logic       frame_stored;

    // scan side
    fb_addr_t   scan_addr;
    logic [2:0] scan_row;
    lcd_col_t   col0;
    lcd_col_t   col1;
    lcd_col_t   col2;
    lcd_col_t   col3;
    logic [2:0] row_q;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    lcd_capture #(
        .LCD_XSIZE (LCD_XSIZE),
        .LCD_YSIZE (LCD_YSIZE)
    ) i_lcd_capture (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .frame_done   (frame_done),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .col_we       (col_we),
        .col_addr     (col_addr),
        .col_data     (col_data),
        .frame_stored (frame_stored)
    );

    frame_store #(
        .LCD_XSIZE (LCD_XSIZE)
    ) i_frame_store (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .col_we       (col_we),
        .col_addr     (col_addr),
        .col_data     (col_data),
        .frame_stored (frame_stored),
        .scan_addr    (scan_addr),
        .scan_row     (scan_row),
        .col0         (col0),
        .col1         (col1),
        .col2         (col2),
        .col3         (col3),
        .row_q        (row_q)
    );

    //////////////////////////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////////////////////////

    video_timing #(
        .H_TOTAL   (H_TOTAL),
        .V_TOTAL   (V_TOTAL),
        .LCD_XSIZE (LCD_XSIZE),
        .LCD_YSIZE (LCD_YSIZE)
    ) i_video_timing (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .pix_ce    (pix_ce),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblank    (hblank),
        .vblank    (vblank),
        .scan_addr (scan_addr),
        .scan_row  (scan_row)
    );

    pixel_blend i_pixel_blend (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .contrast (contrast),
        .col0     (col0),
        .col1     (col1),
        .col2     (col2),
        .col3     (col3),
        .row_q    (row_q),
        .pixel    (pixel)
    );

endmodule

// ==== src/pixel_blend.sv ====
module pixel_blend (
    input  logic               clk_sys,
    input  logic               reset,
    input  lcd_pkg::contrast_t contrast,
    input  lcd_pkg::lcd_col_t  col0,
    input  lcd_pkg::lcd_col_t  col1,
    input  lcd_pkg::lcd_col_t  col2,
    input  lcd_pkg::lcd_col_t  col3,
    input  logic [2:0]         row_q,
    output lcd_pkg::pixel_t    pixel
);
    import lcd_pkg::*;

    pixel_t     on_level;
    lcd_col_t   cols [4];
    logic [9:0] sum;

    // contrast 0x20 and up saturates to full white
    assign on_level = (contrast >= 6'h20) ? 8'hff : {contrast[4:0], 3'b000};

    assign cols[0] = col0;
    assign cols[1] = col1;
    assign cols[2] = col2;
    assign cols[3] = col3;

    //////////////////////////////////////////////////////////////////////
    // four frame ghosting blend
    //////////////////////////////////////////////////////////////////////

    // a cleared bit counts as lit in that capture
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < 4; i++)
        begin
            if (!cols[i][row_q])
                sum = sum + 10'(on_level);
        end
    end

    // average of four, fits back into 8 bits
    always_ff @(posedge clk_sys)
    begin
        if (reset)
            pixel <= '0;
        else
            pixel <= sum[9:2];
    end

endmodule

// ==== src/video_timing.sv ====
module video_timing #(
    parameter int H_TOTAL   = 140,
    parameter int V_TOTAL   = 119,
    parameter int LCD_XSIZE = 96,
    parameter int LCD_YSIZE = 64
) (
    input  logic              clk_sys,
    input  logic              reset,
    output logic              pix_ce,
    output logic              hsync,
    output logic              vsync,
    output logic              hblank,
    output logic              vblank,
    output lcd_pkg::fb_addr_t scan_addr,
    output logic [2:0]        scan_row
);
    import lcd_pkg::*;

    // raster landmarks in pixel strobes and lines
    localparam int H_ACT_START = 16;
    localparam int V_ACT_START = 32;
    localparam int HSYNC_START = 120;
    localparam int HSYNC_LEN   = 16;
    localparam int VSYNC_FIRST = 1;
    localparam int VSYNC_LAST  = 4;

    logic [1:0] prescale;
    raster_t    hpos;
    raster_t    vpos;
    raster_t    scan_x;
    raster_t    scan_y;

    // one pixel strobe every four clocks
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            prescale <= '0;
            pix_ce   <= 1'b0;
        end
        else
        begin
            prescale <= prescale + 1'b1;
            pix_ce   <= (prescale == 2'd2);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // raster counters, sync, blanking and scan position
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            hpos   <= '0;
            vpos   <= '0;
            scan_x <= '0;
            scan_y <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblank <= 1'b1;
            vblank <= 1'b1;
        end
        else if (pix_ce)
        begin
            if (hpos == raster_t'(H_ACT_START + LCD_XSIZE))
                hblank <= 1'b1;
            if (hpos == raster_t'(H_ACT_START))
                hblank <= 1'b0;
            if (vpos >= raster_t'(V_ACT_START + LCD_YSIZE))
                vblank <= 1'b1;
            if (vpos == raster_t'(V_ACT_START))
                vblank <= 1'b0;

            // vsync edges line up with the hsync leading edge
            if (hpos == raster_t'(HSYNC_START))
            begin
                hsync <= 1'b1;
                if (vpos == raster_t'(VSYNC_FIRST))
                    vsync <= 1'b1;
                if (vpos == raster_t'(VSYNC_LAST))
                    vsync <= 1'b0;
            end
            if (hpos == raster_t'(HSYNC_START + HSYNC_LEN))
                hsync <= 1'b0;

            if (hpos == raster_t'(H_TOTAL - 1))
            begin
                hpos <= '0;
                if (vpos == raster_t'(V_TOTAL - 1))
                    vpos <= '0;
                else
                    vpos <= vpos + 1'b1;
            end
            else
            begin
                hpos <= hpos + 1'b1;
            end

            // scan restarts each vertical blank, steps only on active pixels
            if (vblank)
            begin
                scan_x <= '0;
                scan_y <= '0;
            end
            else if (!hblank)
            begin
                if (scan_x == raster_t'(LCD_XSIZE - 1))
                begin
                    scan_x <= '0;
                    scan_y <= scan_y + 1'b1;
                end
                else
                begin
                    scan_x <= scan_x + 1'b1;
                end
            end
        end
    end

    // band selects the column row, low bits select the pixel in it
    assign scan_addr = fb_addr_t'((scan_y >> 3) * LCD_XSIZE + scan_x);
    assign scan_row  = scan_y[2:0];

endmodule

// ==== verification/frame_input.hex ====
// seed contrast on_level, one captured frame per line, all hex
// the seed is mixed with the base seed before the lcd memory is filled
0000a3c1 1f f8
00003b72 10 80
0007e9d5 20 ff
0000c64e 08 40
00051f27 3a ff
0002d8b3 1b d8

// ==== verification/lcd_video_checker.sv ====
module lcd_video_checker #(
    parameter int H_TOTAL     = 140,
    parameter int V_TOTAL     = 119,
    parameter int LCD_XSIZE   = 96,
    parameter int LCD_YSIZE   = 64,
    parameter int NUM_RECORDS = 6
) (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               frame_done,
    input  lcd_pkg::contrast_t contrast,
    input  lcd_pkg::pixel_t    exp_on,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  lcd_pkg::fb_addr_t  wb_adr,
    input  lcd_pkg::lcd_col_t  wb_dat,
    input  logic               wb_ack,
    input  logic               pix_ce,
    input  logic               hsync,
    input  logic               vsync,
    input  logic               hblank,
    input  logic               vblank,
    input  lcd_pkg::pixel_t    pixel,
    input  logic               report,
    output logic               report_done,
    output int                 error_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import lcd_pkg::*;

    localparam int COLS          = LCD_XSIZE * LCD_YSIZE / 8;
    localparam int FRAME_STROBES = H_TOTAL * V_TOTAL;
    localparam int FRAME_ACTIVE  = LCD_XSIZE * LCD_YSIZE;
    // raster landmarks in strobes, vsync as a linear frame position
    localparam int H_ACT  = 16;
    localparam int V_ACT  = 32;
    localparam int HS_ON  = 120;
    localparam int HS_OFF = 136;
    localparam int VS_ON  = 1 * H_TOTAL + 120;
    localparam int VS_OFF = 4 * H_TOTAL + 120;

    // model of the buffer ring
    lcd_col_t model [4][COLS];
    int       wr_buf;
    int       exp_adr;
    int       captures;
    logic     capture_open;
    logic     prev_ack;
    logic     prev_req;
    fb_addr_t prev_adr;
    pixel_t   cur_on;

    // raster mirror
    int       h_cnt;
    int       v_cnt;
    int       ce_gap;
    int       strobes;
    int       actives;
    int       sx;
    int       sy;
    int       pixel_checks;
    logic     exp_hsync;
    logic     exp_vsync;
    logic     exp_hblank;
    logic     exp_vblank;
    logic     prev_vsync;
    logic     vsync_seen;

    int       bus_errors;
    int       raster_errors;
    int       level_errors;
    int       pixel_errors;
    int       other_errors;

    assign error_count = bus_errors + raster_errors + level_errors + pixel_errors +
                         other_errors;

    // contrast register to "on" level
    function automatic pixel_t on_level(input contrast_t c);
        if (c >= 6'h20)
            return 8'hff;
        return pixel_t'(int'(c[4:0]) * 8);
    endfunction

    // lit captures at one pixel, averaged over the ring
    function automatic pixel_t expected_pixel(input int x, input int y);
        int addr;
        int lit;
        addr = (y / 8) * LCD_XSIZE + x;
        lit  = 0;
        for (int b = 0; b < 4; b++)
        begin
            if (model[b][addr][y % 8] == 1'b0)
                lit++;
        end
        return pixel_t'((int'(cur_on) * lit) / 4);
    endfunction

    function automatic void show_mismatch(input string name, input int got, input int exp);
        $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endfunction

    always @(posedge clk_sys)
    begin
        if (reset)
        begin
            wr_buf        = 0;
            exp_adr       = 0;
            captures      = 0;
            capture_open  = 1'b0;
            prev_ack      = 1'b0;
            prev_req      = 1'b0;
            prev_adr      = '0;
            cur_on        = '0;
            h_cnt         = 0;
            v_cnt         = 0;
            ce_gap        = 0;
            strobes       = 0;
            actives       = 0;
            sx            = 0;
            sy            = 0;
            pixel_checks  = 0;
            // reset values of the video outputs
            exp_hsync     = 1'b0;
            exp_vsync     = 1'b0;
            exp_hblank    = 1'b1;
            exp_vblank    = 1'b1;
            prev_vsync    = 1'b0;
            vsync_seen    = 1'b0;
            bus_errors    = 0;
            raster_errors = 0;
            level_errors  = 0;
            pixel_errors  = 0;
            other_errors  = 0;
            report_done  <= 1'b0;
        end
        else
        begin
            //////////////////////////////////////////////////////////////////////
            // capture side
            //////////////////////////////////////////////////////////////////////

            if (frame_done)
            begin
                if (capture_open)
                begin
                    $display("frame_done came before the previous capture finished");
                    bus_errors++;
                end
                if (on_level(contrast) != exp_on)
                begin
                    show_mismatch("on_level", int'(on_level(contrast)), int'(exp_on));
                    level_errors++;
                end
                capture_open = 1'b1;
                cur_on       = exp_on;
            end
            if (wb_cyc != wb_stb)
            begin
                $display("wb_cyc and wb_stb disagree at %0t", $time);
                bus_errors++;
            end
            if (wb_cyc && !capture_open)
            begin
                $display("wishbone request without a pending capture at %0t", $time);
                bus_errors++;
            end
            // one idle cycle after every acknowledge
            if (prev_ack && wb_cyc)
            begin
                $display("request still high the cycle after acknowledge at %0t", $time);
                bus_errors++;
            end
            if (prev_req && !prev_ack && wb_stb && (wb_adr != prev_adr))
            begin
                show_mismatch("wb_adr", int'(wb_adr), int'(prev_adr));
                bus_errors++;
            end
            if (wb_cyc && wb_stb && wb_ack)
            begin
                if (wb_adr != fb_addr_t'(exp_adr))
                begin
                    show_mismatch("wb_adr", int'(wb_adr), exp_adr);
                    bus_errors++;
                end
                model[wr_buf][wb_adr] = wb_dat;
                // last column closes the capture and moves the ring on
                if (exp_adr == COLS - 1)
                begin
                    exp_adr      = 0;
                    wr_buf       = (wr_buf + 1) % 4;
                    captures++;
                    capture_open = 1'b0;
                end
                else
                begin
                    exp_adr++;
                end
            end
            prev_ack = wb_cyc && wb_stb && wb_ack;
            prev_req = wb_cyc && wb_stb;
            prev_adr = wb_adr;

            //////////////////////////////////////////////////////////////////////
            // raster and pixels, sampled on the strobe
            //////////////////////////////////////////////////////////////////////

            if (!pix_ce)
            begin
                ce_gap++;
            end
            else
            begin
                if (ce_gap != 3)
                begin
                    $display("pix_ce came %0d clocks after the previous one", ce_gap + 1);
                    raster_errors++;
                end
                ce_gap = 0;
                if (hsync !== exp_hsync)
                begin
                    show_mismatch("hsync", int'(hsync), int'(exp_hsync));
                    raster_errors++;
                end
                if (vsync !== exp_vsync)
                begin
                    show_mismatch("vsync", int'(vsync), int'(exp_vsync));
                    raster_errors++;
                end
                if (hblank !== exp_hblank)
                begin
                    show_mismatch("hblank", int'(hblank), int'(exp_hblank));
                    raster_errors++;
                end
                if (vblank !== exp_vblank)
                begin
                    show_mismatch("vblank", int'(vblank), int'(exp_vblank));
                    raster_errors++;
                end

                // frame length between vsync rising edges
                if (vsync && !prev_vsync)
                begin
                    if (vsync_seen && (strobes != FRAME_STROBES))
                    begin
                        $display("frame had %0d pixel strobes, expected %0d",
                                 strobes, FRAME_STROBES);
                        raster_errors++;
                    end
                    if (vsync_seen && (actives != FRAME_ACTIVE))
                    begin
                        $display("frame had %0d active pixels, expected %0d",
                                 actives, FRAME_ACTIVE);
                        raster_errors++;
                    end
                    strobes    = 0;
                    actives    = 0;
                    vsync_seen = 1'b1;
                end
                prev_vsync = vsync;
                strobes++;

                if (vblank)
                begin
                    sx = 0;
                    sy = 0;
                end
                else if (!hblank)
                begin
                    actives++;
                    // all four buffers hold a capture from here on
                    if (captures >= 4)
                    begin
                        pixel_checks++;
                        if (pixel !== expected_pixel(sx, sy))
                        begin
                            show_mismatch("pixel", int'(pixel), int'(expected_pixel(sx, sy)));
                            pixel_errors++;
                        end
                    end
                    if (sx == LCD_XSIZE - 1)
                    begin
                        sx = 0;
                        sy++;
                    end
                    else
                    begin
                        sx++;
                    end
                end

                // outputs expected after this strobe's position
                exp_hsync  = (h_cnt >= HS_ON) && (h_cnt < HS_OFF);
                exp_vsync  = (v_cnt * H_TOTAL + h_cnt >= VS_ON) &&
                             (v_cnt * H_TOTAL + h_cnt < VS_OFF);
                exp_hblank = !((h_cnt >= H_ACT) && (h_cnt < H_ACT + LCD_XSIZE));
                exp_vblank = !((v_cnt >= V_ACT) && (v_cnt < V_ACT + LCD_YSIZE));
                if (h_cnt == H_TOTAL - 1)
                begin
                    h_cnt = 0;
                    v_cnt = (v_cnt == V_TOTAL - 1) ? 0 : v_cnt + 1;
                end
                else
                begin
                    h_cnt++;
                end
            end

            // closing line
            if (report && !report_done)
            begin
                if (captures != NUM_RECORDS)
                begin
                    $display("saw %0d completed captures, expected %0d", captures, NUM_RECORDS);
                    other_errors++;
                end
                if (pixel_checks < (NUM_RECORDS - 3) * FRAME_ACTIVE)
                begin
                    $display("only %0d pixels were compared", pixel_checks);
                    other_errors++;
                end
                $display("errors: bus %0d raster %0d level %0d pixel %0d other %0d (%0d pixels)",
                         bus_errors, raster_errors, level_errors, pixel_errors,
                         other_errors, pixel_checks);
                report_done <= 1'b1;
            end
        end
    end

endmodule

// ==== verification/tb_lcd_video.sv ====
module tb_lcd_video;
    timeunit 1ns;
    timeprecision 100ps;
    import lcd_pkg::*;

    // geometry matches the top level defaults
    localparam int H_TOTAL     = 140;
    localparam int V_TOTAL     = 119;
    localparam int LCD_XSIZE   = 96;
    localparam int LCD_YSIZE   = 64;
    localparam int NUM_RECORDS = 6;
    localparam int CLK_PERIOD  = 10;
    localparam int COLS        = LCD_XSIZE * LCD_YSIZE / 8;
    localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL * 4;
    // one frame per capture plus one before the first and one to show the last
    localparam int WATCHDOG_NS = (NUM_RECORDS + 2) * FRAME_CLKS * CLK_PERIOD;

    logic        clk_sys;
    logic        reset;
    logic        frame_done;
    contrast_t   contrast;
    pixel_t      exp_on;
    logic        wb_cyc;
    logic        wb_stb;
    fb_addr_t    wb_adr;
    lcd_col_t    wb_dat = '0;
    logic        wb_ack = 1'b0;
    logic        pix_ce;
    logic        hsync;
    logic        vsync;
    logic        hblank;
    logic        vblank;
    pixel_t      pixel;
    logic        report;
    logic        report_done;
    int          error_count;

    // seed, contrast and "on" level per record
    logic [31:0] rec_words [3 * NUM_RECORDS];
    // lcd column memory served over wishbone
    lcd_col_t    lcd_mem [COLS];
    logic [31:0] wait_state;
    logic [1:0]  wait_cnt;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // new lcd picture with the address folded in so every column differs
    task automatic fill_lcd(input logic [31:0] seed);
        logic [31:0] s;
        logic [9:0]  a;
        s = seed ^ 32'h14b5;
        for (int i = 0; i < COLS; i++)
        begin
            s = xorshift(s);
            a = 10'(i);
            lcd_mem[i] = s[7:0] ^ a[7:0] ^ {6'b0, a[9:8]};
        end
    endtask

    lcd_video_top #(
        .H_TOTAL   (H_TOTAL),
        .V_TOTAL   (V_TOTAL),
        .LCD_XSIZE (LCD_XSIZE),
        .LCD_YSIZE (LCD_YSIZE)
    ) i_dut (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .frame_done (frame_done),
        .contrast   (contrast),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .pix_ce     (pix_ce),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblank     (hblank),
        .vblank     (vblank),
        .pixel      (pixel)
    );

    lcd_video_checker #(
        .H_TOTAL     (H_TOTAL),
        .V_TOTAL     (V_TOTAL),
        .LCD_XSIZE   (LCD_XSIZE),
        .LCD_YSIZE   (LCD_YSIZE),
        .NUM_RECORDS (NUM_RECORDS)
    ) i_checker (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .frame_done  (frame_done),
        .contrast    (contrast),
        .exp_on      (exp_on),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat      (wb_dat),
        .wb_ack      (wb_ack),
        .pix_ce      (pix_ce),
        .hsync       (hsync),
        .vsync       (vsync),
        .hblank      (hblank),
        .vblank      (vblank),
        .pixel       (pixel),
        .report      (report),
        .report_done (report_done),
        .error_count (error_count)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    //////////////////////////////////////////////////////////////////////
    // wishbone slave with 0 to 3 random wait states per read
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_sys)
    begin
        if (reset)
        begin
            wb_ack     <= 1'b0;
            wait_cnt   <= 2'd0;
            wait_state <= 32'h14b5;
        end
        else if (wb_ack)
        begin
            wb_ack <= 1'b0;
        end
        else if (wb_cyc && wb_stb)
        begin
            if (wait_cnt == 2'd0)
            begin
                wb_ack     <= 1'b1;
                wb_dat     <= lcd_mem[wb_adr];
                wait_state <= xorshift(wait_state);
                // next read gets a fresh delay
                wait_cnt   <= wait_state[9:8];
            end
            else
            begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // record sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        reset      = 1'b1;
        frame_done = 1'b0;
        contrast   = '0;
        exp_on     = '0;
        report     = 1'b0;
        // all ones marks a word the file did not supply
        for (int i = 0; i < 3 * NUM_RECORDS; i++)
            rec_words[i] = '1;
        $readmemh("verification/frame_input.hex", rec_words);
        if (rec_words[3 * NUM_RECORDS - 1] === '1)
        begin
            $display("could not read all records from verification/frame_input.hex");
            $display("** FAIL **");
        end
        else
        begin
            repeat (10) @(posedge clk_sys);
            reset <= 1'b0;
            // one capture per frame started from the vsync edge
            for (int r = 0; r < NUM_RECORDS; r++)
            begin
                @(posedge vsync);
                fill_lcd(rec_words[3 * r]);
                @(posedge clk_sys);
                contrast   <= contrast_t'(rec_words[3 * r + 1]);
                exp_on     <= pixel_t'(rec_words[3 * r + 2]);
                frame_done <= 1'b1;
                @(posedge clk_sys);
                frame_done <= 1'b0;
            end
            // last capture gets one full frame on screen
            @(posedge vsync);
            @(posedge clk_sys);
            report <= 1'b1;
            wait (report_done);
            if (error_count == 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/lcd_pkg.sv
src/lcd_capture.sv
src/frame_store.sv
src/video_timing.sv
src/pixel_blend.sv
src/lcd_video_top.sv
verification/lcd_video_checker.sv
verification/tb_lcd_video.sv
